//--- bench/tb_axi_vfifo.sv
`timescale 1ns/1ps
`include "vfifo_config.svh"

module tb_axi_vfifo;
    import vfifo_pkg::*;

    localparam int    TOTAL_WORDS = 64 + 64 + 4 + 40 + 4 + 14;
    localparam int    BURST_BYTES = (1 << `VFIFO_LG_BURST) * (`VFIFO_DATA_W / 8);
    localparam addr_t BASE_ADDR   = 32'h4000_0000;

    logic       S_AXI_ACLK;
    logic       S_AXI_ARESETN;
    logic       s_valid;
    logic       s_ready;
    data_t      s_data;
    logic       m_valid;
    logic       m_ready;
    data_t      m_data;
    logic       aw_valid;
    logic       aw_ready;
    addr_t      aw_addr;
    logic       w_valid;
    logic       w_ready;
    mem_wdata_t w;
    logic       b_valid;
    logic       ar_valid;
    logic       ar_ready;
    addr_t      ar_addr;
    logic       r_valid;
    mem_rdata_t r;
    logic       soft_rst;
    addr_t      base_addr;
    addr_t      addr_mask;
    vfill_t     vfifo_fill;
    logic       vfifo_empty;
    logic [7:0] b_delay;
    logic       watch_b;
    logic       b_seen;
    logic       early_ar;
    logic [31:0] rng_state;
    data_t      exp_q[$];
    int         mismatches;
    int         errors;

    axi_vfifo u_dut (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .i_s_valid     (s_valid),
        .o_s_ready     (s_ready),
        .i_s_data      (s_data),
        .o_m_valid     (m_valid),
        .i_m_ready     (m_ready),
        .o_m_data      (m_data),
        .o_aw_valid    (aw_valid),
        .i_aw_ready    (aw_ready),
        .o_aw_addr     (aw_addr),
        .o_w_valid     (w_valid),
        .i_w_ready     (w_ready),
        .o_w           (w),
        .i_b_valid     (b_valid),
        .o_ar_valid    (ar_valid),
        .i_ar_ready    (ar_ready),
        .o_ar_addr     (ar_addr),
        .i_r_valid     (r_valid),
        .i_r           (r),
        .i_soft_rst    (soft_rst),
        .i_base_addr   (base_addr),
        .i_addr_mask   (addr_mask),
        .o_vfifo_fill  (vfifo_fill),
        .o_vfifo_empty (vfifo_empty)
    );

    tb_mem_model u_mem (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .i_b_delay     (b_delay),
        .i_aw_valid    (aw_valid),
        .o_aw_ready    (aw_ready),
        .i_aw_addr     (aw_addr),
        .i_w_valid     (w_valid),
        .o_w_ready     (w_ready),
        .i_w           (w),
        .o_b_valid     (b_valid),
        .i_ar_valid    (ar_valid),
        .o_ar_ready    (ar_ready),
        .i_ar_addr     (ar_addr),
        .o_r_valid     (r_valid),
        .o_r           (r)
    );

    initial begin
        S_AXI_ACLK = 1'b0;
    end

    always #2 S_AXI_ACLK = ~S_AXI_ACLK;

    // Watches for an AR that gets ahead of the first B while armed
    always @(posedge S_AXI_ACLK) begin
        if (!watch_b) begin
            b_seen   <= 1'b0;
            early_ar <= 1'b0;
        end else begin
            if (b_valid) begin
                b_seen <= 1'b1;
            end
            if (ar_valid && ar_ready && !b_seen && !b_valid) begin
                early_ar <= 1'b1;
            end
        end
    end

    initial begin
        repeat (200 * TOTAL_WORDS) @(posedge S_AXI_ACLK);
        $display("ERROR: run timed out after %0d cycles", 200 * TOTAL_WORDS);
        $display("Done: errors found");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic data_t next_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic note_error(input string msg);
        $display("ERROR: %s", msg);
        errors++;
    endtask

    // Holds valid until the DUT takes each word, with gap idle cycles in between
    task automatic send_words(input int n, input int gap);
        data_t word;
        for (int i = 0; i < n; i++) begin
            word = next_word();
            @(negedge S_AXI_ACLK);
            s_valid = 1'b1;
            s_data  = word;
            @(posedge S_AXI_ACLK);
            while (!s_ready) @(posedge S_AXI_ACLK);
            exp_q.push_back(word);
            repeat (gap) begin
                @(negedge S_AXI_ACLK);
                s_valid = 1'b0;
            end
        end
        @(negedge S_AXI_ACLK);
        s_valid = 1'b0;
    endtask

    task automatic recv_words(input int n);
        data_t exp;
        for (int i = 0; i < n; i++) begin
            @(posedge S_AXI_ACLK);
            while (!(m_valid && m_ready)) @(posedge S_AXI_ACLK);
            if (exp_q.size() == 0) begin
                note_error($sformatf("output word %0d arrived with nothing expected", i));
            end else begin
                exp = exp_q.pop_front();
                check_value("o_m_data", m_data, exp);
            end
        end
    endtask

    task automatic addressing_test();
        addr_t exp_addr;
        @(negedge S_AXI_ACLK);
        m_ready = 1'b1;
        fork
            send_words(64, 1);
            recv_words(64);
        join
        check_value("aw_count", u_mem.aw_count, 16);
        check_value("ar_count", u_mem.ar_count, 16);
        for (int k = 0; k < 16; k++) begin
            exp_addr = base_addr + (addr_t'(k * BURST_BYTES) & addr_mask);
            check_value($sformatf("o_aw_addr[%0d]", k), u_mem.aw_log[k], exp_addr);
            check_value($sformatf("o_ar_addr[%0d]", k), u_mem.ar_log[k], exp_addr);
        end
    endtask

    task automatic ordering_test();
        @(negedge S_AXI_ACLK);
        m_ready = 1'b1;
        fork
            send_words(64, 0);
            recv_words(64);
        join
    endtask

    task automatic partial_burst_test();
        int   n_aw;
        logic seen_valid;
        n_aw = u_mem.aw_count;
        seen_valid = 1'b0;
        send_words(3, 0);
        repeat (20) begin
            @(posedge S_AXI_ACLK);
            if (m_valid) begin
                seen_valid = 1'b1;
            end
        end
        if (seen_valid) begin
            note_error("output went valid before a full burst was written");
        end
        check_value("aw_count", u_mem.aw_count, n_aw);
        fork
            send_words(1, 0);
            recv_words(4);
        join
        check_value("aw_count", u_mem.aw_count, n_aw + 1);
    endtask

    task automatic backpressure_test();
        int wait_cycles;
        @(negedge S_AXI_ACLK);
        m_ready = 1'b0;
        send_words(40, 0);
        repeat (2) @(posedge S_AXI_ACLK);
        check_value("o_vfifo_fill", vfifo_fill, 40);
        @(negedge S_AXI_ACLK);
        m_ready = 1'b1;
        recv_words(40);
        wait_cycles = 0;
        @(posedge S_AXI_ACLK);
        while (!vfifo_empty && wait_cycles < 16) begin
            @(posedge S_AXI_ACLK);
            wait_cycles++;
        end
        if (!vfifo_empty) begin
            note_error("virtual FIFO not empty after all words were read back");
        end
        check_value("o_vfifo_fill", vfifo_fill, 0);
    endtask

    task automatic read_after_b_test();
        int n_ar;
        n_ar = u_mem.ar_count;
        @(negedge S_AXI_ACLK);
        b_delay = 8'd20;
        watch_b = 1'b1;
        fork
            send_words(4, 0);
            recv_words(4);
        join
        if (early_ar) begin
            note_error("an AR was accepted before the first B response");
        end
        if (!b_seen) begin
            note_error("no B response was seen during the burst");
        end
        check_value("ar_count", u_mem.ar_count, n_ar + 1);
        @(negedge S_AXI_ACLK);
        watch_b = 1'b0;
        b_delay = 8'd0;
    endtask

    task automatic soft_reset_test();
        int wait_cycles;
        int n_aw;
        int n_ar;
        @(negedge S_AXI_ACLK);
        m_ready = 1'b0;
        send_words(10, 0);
        @(negedge S_AXI_ACLK);
        soft_rst = 1'b1;
        @(negedge S_AXI_ACLK);
        soft_rst = 1'b0;
        // Whatever was in flight is thrown away by the soft reset
        exp_q.delete();
        wait_cycles = 0;
        @(posedge S_AXI_ACLK);
        while (!s_ready && wait_cycles < 400) begin
            @(posedge S_AXI_ACLK);
            wait_cycles++;
        end
        if (!s_ready) begin
            note_error("input stayed blocked after the soft reset");
        end
        check_value("o_vfifo_empty", vfifo_empty, 1);
        check_value("o_vfifo_fill", vfifo_fill, 0);
        check_value("o_m_valid", m_valid, 0);
        n_aw = u_mem.aw_count;
        n_ar = u_mem.ar_count;
        @(negedge S_AXI_ACLK);
        m_ready = 1'b1;
        fork
            send_words(4, 0);
            recv_words(4);
        join
        check_value("o_aw_addr", u_mem.aw_log[n_aw], base_addr);
        check_value("o_ar_addr", u_mem.ar_log[n_ar], base_addr);
    endtask

    initial begin
        S_AXI_ARESETN = 1'b0;
        s_valid = 1'b0;
        s_data = '0;
        m_ready = 1'b0;
        soft_rst = 1'b0;
        base_addr = BASE_ADDR;
        addr_mask = 32'h0000_003F;
        b_delay = 8'd0;
        watch_b = 1'b0;
        rng_state = 32'hac18816b;
        mismatches = 0;
        errors = 0;
        repeat (3) @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b1;
        @(posedge S_AXI_ACLK);
        check_value("o_aw_valid", aw_valid, 0);
        check_value("o_w_valid", w_valid, 0);
        check_value("o_ar_valid", ar_valid, 0);
        check_value("o_m_valid", m_valid, 0);
        check_value("o_vfifo_empty", vfifo_empty, 1);

        // Offsets start at zero here, so the small mask wraps from a known point
        addressing_test();
        @(negedge S_AXI_ACLK);
        addr_mask = 32'h0000_0FFF;
        ordering_test();
        partial_burst_test();
        backpressure_test();
        read_after_b_test();
        soft_reset_test();

        $display("Summary: %0d value mismatches, %0d other errors", mismatches, errors);
        if (mismatches == 0 && errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- bench/tb_mem_model.sv
`timescale 1ns/1ps
`include "vfifo_config.svh"

module tb_mem_model (
    input  logic                  S_AXI_ACLK,
    input  logic                  S_AXI_ARESETN,
    input  logic [7:0]            i_b_delay,
    input  logic                  i_aw_valid,
    output logic                  o_aw_ready,
    input  vfifo_pkg::addr_t      i_aw_addr,
    input  logic                  i_w_valid,
    output logic                  o_w_ready,
    input  vfifo_pkg::mem_wdata_t i_w,
    output logic                  o_b_valid,
    input  logic                  i_ar_valid,
    output logic                  o_ar_ready,
    input  vfifo_pkg::addr_t      i_ar_addr,
    output logic                  o_r_valid,
    output vfifo_pkg::mem_rdata_t o_r
);
    import vfifo_pkg::*;

    localparam int BEATS     = 1 << `VFIFO_LG_BURST;
    localparam int BYTES     = `VFIFO_DATA_W / 8;
    localparam int MEM_WORDS = 1024;
    localparam int LOG_LEN   = 256;

    data_t mem [MEM_WORDS];
    addr_t aw_log [LOG_LEN];
    addr_t ar_log [LOG_LEN];
    int    aw_count;
    int    ar_count;
    int    cyc;
    int    w_beat;
    int    rd_beat;
    logic  rd_active;
    addr_t rd_addr;
    addr_t wr_q[$];
    addr_t rd_q[$];
    int    b_due[$];

    // Every channel is always ready, so a valid is a transfer
    assign o_aw_ready = 1'b1;
    assign o_w_ready  = 1'b1;
    assign o_ar_ready = 1'b1;

    // Only the low address bits select a word, so a masked range aliases cleanly
    function automatic int word_index(input addr_t a);
        return int'((a >> `VFIFO_ADDR_LSB) & addr_t'(MEM_WORDS - 1));
    endfunction

    always @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            aw_count = 0;
            ar_count = 0;
            cyc = 0;
            w_beat = 0;
            rd_beat = 0;
            rd_active = 1'b0;
            wr_q.delete();
            rd_q.delete();
            b_due.delete();
            o_b_valid <= 1'b0;
            o_r_valid <= 1'b0;
            o_r <= '0;
        end else begin
            cyc = cyc + 1;
            // AW is handled first since it can arrive with the first W beat
            if (i_aw_valid) begin
                if (aw_count < LOG_LEN) begin
                    aw_log[aw_count] = i_aw_addr;
                end
                aw_count = aw_count + 1;
                wr_q.push_back(i_aw_addr);
            end
            if (i_w_valid && wr_q.size() > 0) begin
                mem[word_index(wr_q[0] + addr_t'(w_beat * BYTES))] = i_w.data;
                w_beat = w_beat + 1;
                if (i_w.last) begin
                    wr_q.delete(0);
                    w_beat = 0;
                    b_due.push_back(cyc + int'(i_b_delay));
                end
            end
            o_b_valid <= 1'b0;
            if (b_due.size() > 0 && b_due[0] <= cyc) begin
                b_due.delete(0);
                o_b_valid <= 1'b1;
            end
            if (i_ar_valid) begin
                if (ar_count < LOG_LEN) begin
                    ar_log[ar_count] = i_ar_addr;
                end
                ar_count = ar_count + 1;
                rd_q.push_back(i_ar_addr);
            end
            // Read bursts are served one after another at a beat per cycle
            o_r_valid <= 1'b0;
            if (!rd_active && rd_q.size() > 0) begin
                rd_addr = rd_q.pop_front();
                rd_beat = 0;
                rd_active = 1'b1;
            end
            if (rd_active) begin
                o_r_valid <= 1'b1;
                o_r.data <= mem[word_index(rd_addr + addr_t'(rd_beat * BYTES))];
                o_r.last <= (rd_beat == BEATS - 1);
                rd_beat = rd_beat + 1;
                if (rd_beat == BEATS) begin
                    rd_active = 1'b0;
                end
            end
        end
    end

endmodule

//--- compile.f
+incdir+source
source/vfifo_pkg.sv
source/sync_fifo.sv
source/vfifo_write_engine.sv
source/vfifo_read_engine.sv
source/vfifo_tracker.sv
source/axi_vfifo.sv
bench/tb_mem_model.sv
bench/tb_axi_vfifo.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f \
    --top-module tb_axi_vfifo -o tb_axi_vfifo
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_axi_vfifo)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

//--- source/axi_vfifo.sv
`timescale 1ns/1ps
`include "vfifo_config.svh"

module axi_vfifo (
    input  logic                  S_AXI_ACLK,
    input  logic                  S_AXI_ARESETN,
    input  logic                  i_s_valid,
    output logic                  o_s_ready,
    input  vfifo_pkg::data_t      i_s_data,
    output logic                  o_m_valid,
    input  logic                  i_m_ready,
    output vfifo_pkg::data_t      o_m_data,
    output logic                  o_aw_valid,
    input  logic                  i_aw_ready,
    output vfifo_pkg::addr_t      o_aw_addr,
    output logic                  o_w_valid,
    input  logic                  i_w_ready,
    output vfifo_pkg::mem_wdata_t o_w,
    input  logic                  i_b_valid,
    output logic                  o_ar_valid,
    input  logic                  i_ar_ready,
    output vfifo_pkg::addr_t      o_ar_addr,
    input  logic                  i_r_valid,
    input  vfifo_pkg::mem_rdata_t i_r,
    input  logic                  i_soft_rst,
    input  vfifo_pkg::addr_t      i_base_addr,
    input  vfifo_pkg::addr_t      i_addr_mask,
    output vfifo_pkg::vfill_t     o_vfifo_fill,
    output logic                  o_vfifo_empty
);
    import vfifo_pkg::*;

    logic  soft_rst;
    logic  clr;
    logic  in_xfer;
    logic  out_xfer;
    logic  in_full;
    fill_t in_fill;
    data_t in_head;
    logic  out_empty;
    logic  space_ok;
    logic  data_ok;
    logic  vfifo_full;
    logic  wr_start;
    logic  rd_start;
    logic  wr_idle;
    logic  rd_idle;

    assign clr       = !S_AXI_ARESETN || soft_rst;
    assign o_s_ready = !clr && !in_full && !vfifo_full;
    assign in_xfer   = i_s_valid && o_s_ready;
    assign o_m_valid = !out_empty;
    assign out_xfer  = o_m_valid && i_m_ready;

    sync_fifo u_in_fifo (
        .S_AXI_ACLK (S_AXI_ACLK),
        .i_clr      (clr),
        .i_wr       (in_xfer),
        .i_data     (i_s_data),
        .o_full     (in_full),
        .o_fill     (in_fill),
        .i_rd       (o_w_valid && i_w_ready),
        .o_data     (in_head),
        .o_empty    ()
    );

    vfifo_write_engine u_write_engine (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .i_soft_rst    (soft_rst),
        .i_fill        (in_fill),
        .i_space_ok    (space_ok),
        .i_vfifo_full  (vfifo_full),
        .i_fifo_data   (in_head),
        .i_base_addr   (i_base_addr),
        .i_addr_mask   (i_addr_mask),
        .o_aw_valid    (o_aw_valid),
        .i_aw_ready    (i_aw_ready),
        .o_aw_addr     (o_aw_addr),
        .o_w_valid     (o_w_valid),
        .i_w_ready     (i_w_ready),
        .o_w           (o_w),
        .i_b_valid     (i_b_valid),
        .o_start       (wr_start),
        .o_idle        (wr_idle)
    );

    vfifo_read_engine u_read_engine (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .i_clr         (clr),
        .i_soft_rst    (soft_rst),
        .i_data_ok     (data_ok),
        .i_out_taken   (out_xfer),
        .i_base_addr   (i_base_addr),
        .i_addr_mask   (i_addr_mask),
        .o_ar_valid    (o_ar_valid),
        .i_ar_ready    (i_ar_ready),
        .o_ar_addr     (o_ar_addr),
        .i_r_valid     (i_r_valid),
        .i_r_last      (i_r.last),
        .o_start       (rd_start),
        .o_idle        (rd_idle)
    );

    vfifo_tracker u_tracker (
        .S_AXI_ACLK     (S_AXI_ACLK),
        .S_AXI_ARESETN  (S_AXI_ARESETN),
        .i_soft_rst_req (i_soft_rst),
        .i_wr_idle      (wr_idle),
        .i_rd_idle      (rd_idle),
        .i_wr_start     (wr_start),
        .i_rd_start     (rd_start),
        .i_b_valid      (i_b_valid),
        .i_r_done       (i_r_valid && i_r.last),
        .i_in_xfer      (in_xfer),
        .i_out_xfer     (out_xfer),
        .o_soft_rst     (soft_rst),
        .o_space_ok     (space_ok),
        .o_data_ok      (data_ok),
        .o_vfifo_full   (vfifo_full),
        .o_vfifo_empty  (o_vfifo_empty),
        .o_vfifo_fill   (o_vfifo_fill)
    );

    // Read space is reserved ahead, so every R beat finds room here
    sync_fifo u_out_fifo (
        .S_AXI_ACLK (S_AXI_ACLK),
        .i_clr      (clr),
        .i_wr       (i_r_valid),
        .i_data     (i_r.data),
        .o_full     (),
        .o_fill     (),
        .i_rd       (out_xfer),
        .o_data     (o_m_data),
        .o_empty    (out_empty)
    );

endmodule

//--- source/sync_fifo.sv
`timescale 1ns/1ps
`include "vfifo_config.svh"

module sync_fifo (
    input  logic             S_AXI_ACLK,
    input  logic             i_clr,
    input  logic             i_wr,
    input  vfifo_pkg::data_t i_data,
    output logic             o_full,
    output vfifo_pkg::fill_t o_fill,
    input  logic             i_rd,
    output vfifo_pkg::data_t o_data,
    output logic             o_empty
);
    import vfifo_pkg::*;

    localparam int DEPTH = 1 << `VFIFO_LG_FIFO;

    data_t mem [DEPTH];
    fill_t wr_ptr;
    fill_t rd_ptr;
    logic  do_wr;
    logic  do_rd;

    // Writes on full and reads on empty are dropped here
    assign do_wr = i_wr && !o_full;
    assign do_rd = i_rd && !o_empty;

    always_ff @(posedge S_AXI_ACLK) begin
        if (do_wr) begin
            mem[wr_ptr[`VFIFO_LG_FIFO-1:0]] <= i_data;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (i_clr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // The pointers carry one wrap bit, so their difference is the fill
    assign o_fill  = wr_ptr - rd_ptr;
    assign o_full  = o_fill[`VFIFO_LG_FIFO];
    assign o_empty = (o_fill == '0);

    // Head of the FIFO is visible without a read cycle
    assign o_data = mem[rd_ptr[`VFIFO_LG_FIFO-1:0]];

endmodule

//--- source/vfifo_config.svh
`ifndef VFIFO_CONFIG_SVH
`define VFIFO_CONFIG_SVH

// Stream and memory word width in bits
`define VFIFO_DATA_W 32

// Byte address width on the memory side
`define VFIFO_ADDR_W 32

// Beats per burst as a power of two, kept small so bursts are 4 beats
`define VFIFO_LG_BURST 2

// On-chip FIFO depth, two bursts so one can fill while the other drains
`define VFIFO_LG_FIFO (`VFIFO_LG_BURST + 1)

// Number of byte-lane bits in an address
`define VFIFO_ADDR_LSB ($clog2(`VFIFO_DATA_W / 8))

`endif

//--- source/vfifo_pkg.sv
`include "vfifo_config.svh"

package vfifo_pkg;

    typedef logic [`VFIFO_DATA_W-1:0] data_t;
    typedef logic [`VFIFO_ADDR_W-1:0] addr_t;

    // Fill or free space of an on-chip FIFO, one extra bit to hold the full count
    typedef logic [`VFIFO_LG_FIFO:0] fill_t;

    // Number of whole bursts that the external memory can hold, plus one bit
    typedef logic [`VFIFO_ADDR_W-`VFIFO_LG_BURST-`VFIFO_ADDR_LSB:0] burst_cnt_t;

    // Virtual FIFO fill counted in words
    typedef logic [`VFIFO_ADDR_W-`VFIFO_ADDR_LSB:0] vfill_t;

    typedef struct packed {
        data_t data;
        logic  last;
    } mem_wdata_t;

    typedef struct packed {
        data_t data;
        logic  last;
    } mem_rdata_t;

    typedef enum logic {
        RUN,
        DRAIN
    } rst_state_t;

endpackage

//--- source/vfifo_read_engine.sv
`timescale 1ns/1ps
`include "vfifo_config.svh"

module vfifo_read_engine (
    input  logic             S_AXI_ACLK,
    input  logic             S_AXI_ARESETN,
    input  logic             i_clr,
    input  logic             i_soft_rst,
    input  logic             i_data_ok,
    input  logic             i_out_taken,
    input  vfifo_pkg::addr_t i_base_addr,
    input  vfifo_pkg::addr_t i_addr_mask,
    output logic             o_ar_valid,
    input  logic             i_ar_ready,
    output vfifo_pkg::addr_t o_ar_addr,
    input  logic             i_r_valid,
    input  logic             i_r_last,
    output logic             o_start,
    output logic             o_idle
);
    import vfifo_pkg::*;

    localparam fill_t FIFO_WORDS  = fill_t'(1 << `VFIFO_LG_FIFO);
    localparam fill_t BURST_WORDS = fill_t'(1 << `VFIFO_LG_BURST);
    localparam addr_t BURST_BYTES = addr_t'(1 << (`VFIFO_LG_BURST + `VFIFO_ADDR_LSB));

    logic       start;
    logic       start_q;
    logic       r_done;
    fill_t      space;
    addr_t      offset;
    burst_cnt_t outstanding;

    assign r_done = i_r_valid && i_r_last;

    // Output FIFO room is claimed when a read starts, so R never has to stall
    always_ff @(posedge S_AXI_ACLK) begin
        if (i_clr) begin
            space <= FIFO_WORDS;
        end else begin
            case ({start, i_out_taken})
                2'b10:   space <= space - BURST_WORDS;
                2'b01:   space <= space + 1'b1;
                2'b11:   space <= space - BURST_WORDS + 1'b1;
                default: space <= space;
            endcase
        end
    end

    always_comb begin
        start = (space >= BURST_WORDS) && i_data_ok;
        if (i_soft_rst || start_q) begin
            start = 1'b0;
        end
        if (o_ar_valid && !i_ar_ready) begin
            start = 1'b0;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            start_q    <= 1'b0;
            o_ar_valid <= 1'b0;
        end else begin
            start_q <= start;
            if (!o_ar_valid || i_ar_ready) begin
                o_ar_valid <= start;
            end
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            offset <= '0;
        end else if (o_ar_valid && i_ar_ready) begin
            offset <= (offset + BURST_BYTES) & i_addr_mask;
        end else if (i_soft_rst && !o_ar_valid) begin
            offset <= '0;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            outstanding <= '0;
        end else begin
            case ({start_q, r_done})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // Idle when no burst is waiting for its final R beat
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            o_idle <= 1'b1;
        end else if (start || o_ar_valid) begin
            o_idle <= 1'b0;
        end else begin
            o_idle <= (outstanding == (r_done ? burst_cnt_t'(1) : burst_cnt_t'(0)));
        end
    end

    assign o_ar_addr = i_base_addr + offset;
    assign o_start   = start;

endmodule

//--- source/vfifo_tracker.sv
`timescale 1ns/1ps
`include "vfifo_config.svh"

module vfifo_tracker (
    input  logic              S_AXI_ACLK,
    input  logic              S_AXI_ARESETN,
    input  logic              i_soft_rst_req,
    input  logic              i_wr_idle,
    input  logic              i_rd_idle,
    input  logic              i_wr_start,
    input  logic              i_rd_start,
    input  logic              i_b_valid,
    input  logic              i_r_done,
    input  logic              i_in_xfer,
    input  logic              i_out_xfer,
    output logic              o_soft_rst,
    output logic              o_space_ok,
    output logic              o_data_ok,
    output logic              o_vfifo_full,
    output logic              o_vfifo_empty,
    output vfifo_pkg::vfill_t o_vfifo_fill
);
    import vfifo_pkg::*;

    localparam int         BURST_AW  = `VFIFO_ADDR_W - `VFIFO_LG_BURST - `VFIFO_ADDR_LSB;
    localparam burst_cnt_t SPACE_MAX = burst_cnt_t'(1) << BURST_AW;
    localparam int         VFILL_W   = $bits(vfill_t);

    rst_state_t state;
    burst_cnt_t mem_data;
    burst_cnt_t mem_space;
    logic       clr;

    // Soft reset holds until both engines have nothing left in flight
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= RUN;
        end else if (i_soft_rst_req) begin
            state <= DRAIN;
        end else if (state == DRAIN && i_wr_idle && i_rd_idle) begin
            state <= RUN;
        end
    end

    assign o_soft_rst = (state == DRAIN);
    assign clr        = !S_AXI_ARESETN || o_soft_rst;

    // Data only counts as readable after its B response
    always_ff @(posedge S_AXI_ACLK) begin
        if (clr) begin
            mem_data  <= '0;
            mem_space <= SPACE_MAX;
        end else begin
            case ({i_b_valid, i_rd_start})
                2'b10:   mem_data <= mem_data + 1'b1;
                2'b01:   mem_data <= mem_data - 1'b1;
                default: mem_data <= mem_data;
            endcase
            case ({i_wr_start, i_r_done})
                2'b10:   mem_space <= mem_space - 1'b1;
                2'b01:   mem_space <= mem_space + 1'b1;
                default: mem_space <= mem_space;
            endcase
        end
    end

    assign o_space_ok = (mem_space != '0);
    assign o_data_ok  = (mem_data != '0) || i_b_valid;

    always_ff @(posedge S_AXI_ACLK) begin
        if (clr) begin
            o_vfifo_fill  <= '0;
            o_vfifo_empty <= 1'b1;
            o_vfifo_full  <= 1'b0;
        end else begin
            case ({i_in_xfer, i_out_xfer})
                2'b10: begin
                    o_vfifo_fill  <= o_vfifo_fill + 1'b1;
                    o_vfifo_empty <= 1'b0;
                    o_vfifo_full  <= &o_vfifo_fill[VFILL_W-2:0];
                end
                2'b01: begin
                    o_vfifo_fill  <= o_vfifo_fill - 1'b1;
                    o_vfifo_full  <= 1'b0;
                    o_vfifo_empty <= (o_vfifo_fill <= vfill_t'(1));
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- source/vfifo_write_engine.sv
`timescale 1ns/1ps
`include "vfifo_config.svh"

module vfifo_write_engine (
    input  logic                  S_AXI_ACLK,
    input  logic                  S_AXI_ARESETN,
    input  logic                  i_soft_rst,
    input  vfifo_pkg::fill_t      i_fill,
    input  logic                  i_space_ok,
    input  logic                  i_vfifo_full,
    input  vfifo_pkg::data_t      i_fifo_data,
    input  vfifo_pkg::addr_t      i_base_addr,
    input  vfifo_pkg::addr_t      i_addr_mask,
    output logic                  o_aw_valid,
    input  logic                  i_aw_ready,
    output vfifo_pkg::addr_t      o_aw_addr,
    output logic                  o_w_valid,
    input  logic                  i_w_ready,
    output vfifo_pkg::mem_wdata_t o_w,
    input  logic                  i_b_valid,
    output logic                  o_start,
    output logic                  o_idle
);
    import vfifo_pkg::*;

    localparam fill_t BURST_WORDS = fill_t'(1 << `VFIFO_LG_BURST);
    localparam addr_t BURST_BYTES = addr_t'(1 << (`VFIFO_LG_BURST + `VFIFO_ADDR_LSB));
    localparam logic [`VFIFO_LG_BURST:0] PEND_FULL = 1 << `VFIFO_LG_BURST;
    localparam logic [`VFIFO_LG_BURST:0] PEND_ONE  = 1;
    localparam logic [`VFIFO_LG_BURST:0] PEND_TWO  = 2;

    logic                     start;
    logic                     start_q;
    logic                     w_last;
    logic                     w_xfer;
    logic [`VFIFO_LG_BURST:0] pending;
    addr_t                    offset;
    burst_cnt_t               outstanding;

    assign w_xfer = o_w_valid && i_w_ready;

    // A new burst needs a full burst waiting and both write channels free
    // The word on W this cycle still sits in the input fill, so it is not counted
    always_comb begin
        start = (i_fill >= (o_w_valid ? BURST_WORDS + 1'b1 : BURST_WORDS)) && i_space_ok;
        if (i_vfifo_full || i_soft_rst || start_q) begin
            start = 1'b0;
        end
        if (o_w_valid && (!i_w_ready || !w_last)) begin
            start = 1'b0;
        end
        if (o_aw_valid && !i_aw_ready) begin
            start = 1'b0;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            start_q    <= 1'b0;
            o_aw_valid <= 1'b0;
            o_w_valid  <= 1'b0;
            pending    <= '0;
        end else begin
            start_q <= start;
            if (!o_aw_valid || i_aw_ready) begin
                o_aw_valid <= start;
            end
            if (start) begin
                o_w_valid <= 1'b1;
            end else if (!o_w_valid || i_w_ready) begin
                o_w_valid <= o_w_valid && !w_last;
            end
            if (start) begin
                pending <= PEND_FULL;
            end else if (w_xfer) begin
                pending <= pending - 1'b1;
            end
        end
    end

    // WLAST looks one beat ahead of the pending count
    always_ff @(posedge S_AXI_ACLK) begin
        if (start) begin
            w_last <= (`VFIFO_LG_BURST == 0);
        end else if (!o_w_valid || i_w_ready) begin
            w_last <= (pending == (o_w_valid ? PEND_TWO : PEND_ONE));
        end
    end

    // Offset steps one burst per accepted AW and returns to zero in soft reset
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            offset <= '0;
        end else if (o_aw_valid && i_aw_ready) begin
            offset <= (offset + BURST_BYTES) & i_addr_mask;
        end else if (i_soft_rst && !o_aw_valid) begin
            offset <= '0;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            outstanding <= '0;
        end else begin
            case ({start_q, i_b_valid})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // Idle once every issued burst has had its B response
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            o_idle <= 1'b1;
        end else if (start || o_w_valid) begin
            o_idle <= 1'b0;
        end else begin
            o_idle <= (outstanding == (i_b_valid ? burst_cnt_t'(1) : burst_cnt_t'(0)));
        end
    end

    assign o_aw_addr = i_base_addr + offset;
    assign o_w.data  = i_fifo_data;
    assign o_w.last  = w_last;
    assign o_start   = start;

endmodule
